// File: Makefile
# Verilator simulation of the sound subsystem
TOP := tb_sound

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the testbench, fails unless it passes"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert -Wno-fatal -f files.f --top-module $(TOP) -o $(TOP)
	@out="$$(./obj_dir/$(TOP))"; echo "$$out"; echo "$$out" | grep -q "^RESULT: PASS$$"

clean:
	rm -rf obj_dir

// File: files.f
+incdir+include
rtl/sound_regs_pkg.sv
rtl/sound_audio_pkg.sv
rtl/sound_src_if.sv
rtl/sound_wb_regs.sv
rtl/sound_voices.sv
rtl/sound_mixer.sv
rtl/sound_top.sv
testbench/tb_sound.sv

// File: rtl/sound_audio_pkg.sv
// audio sample format of the sound block
// saturation limits, speaker levels, divider floor, tone scaling
package sound_audio_pkg;

    // ----------------------------------------------------------
    // sample format
    // ----------------------------------------------------------
    typedef logic signed [15:0] sample_t;   // two's complement PCM

    localparam sample_t SAMPLE_MAX = 16'sd32767;
    localparam sample_t SAMPLE_MIN = -16'sd32768;

    // ----------------------------------------------------------
    // source scaling
    // ----------------------------------------------------------
    localparam sample_t SPK_HIGH = 16'sd16384;    // speaker line high
    localparam sample_t SPK_LOW  = -16'sd16384;   // speaker line low

    // below two clocks the tick would never drop
    localparam logic [15:0] DIV_MIN = 16'd2;

    localparam int TONE_SHIFT = 7;   // 8-bit amplitude up to 15-bit magnitude

endpackage

// File: rtl/sound_mixer.sv
`timescale 1ns/1ps
// three stage saturating mixer
// stage 1 dac + tone, stage 2 + speaker, stage 3 output register
// new_sample three cycles after the source valid
module sound_mixer (
    input  logic                     clk,
    input  logic                     rst_n,
    sound_src_if.mixer               src,
    output sound_audio_pkg::sample_t sample,
    output logic                     new_sample,
    output logic [7:0]               last_sample_hi
);
    import sound_audio_pkg::*;

    logic               s1_valid;
    logic               s2_valid;
    sample_t            s1_sum;     // dac + tone, clipped
    sample_t            s1_spk;     // speaker carried alongside
    sample_t            s2_sum;     // all three, clipped
    logic signed [16:0] raw1;       // unclipped first sum

    // signed add clipped to the 16-bit range
    function automatic sample_t sat_add(input sample_t a, input sample_t b);
        logic signed [16:0] sum;
        sum = a + b;                        // one guard bit
        if (sum > SAMPLE_MAX) begin
            return SAMPLE_MAX;
        end
        if (sum < SAMPLE_MIN) begin
            return SAMPLE_MIN;
        end
        return sample_t'(sum[15:0]);
    endfunction

    assign raw1 = src.dac + src.tone;

    // ----------------------------------------------------------
    // valid bits
    // ----------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else begin
            s1_valid <= src.valid;
            s2_valid <= s1_valid;
        end
    end

    // ----------------------------------------------------------
    // stages 1 and 2, data follows its valid bit
    // ----------------------------------------------------------
    always_ff @(posedge clk) begin
        s1_sum <= sat_add(src.dac, src.tone);
        s1_spk <= src.speaker;
        s2_sum <= sat_add(s1_sum, s1_spk);
    end

    // ----------------------------------------------------------
    // stage 3, output
    // ----------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sample     <= '0;
            new_sample <= 1'b0;
        end else begin
            new_sample <= s2_valid;
            if (s2_valid) begin
                sample <= s2_sum;           // held until the next tick
            end
        end
    end

    assign last_sample_hi = sample[15:8];

    // positive overflow clips to full scale in the next stage
    a_sat_pos: assert property (@(posedge clk) disable iff (!rst_n)
        src.valid && !src.dac[15] && !src.tone[15] && raw1 > SAMPLE_MAX
        |=> s1_sum == SAMPLE_MAX);

endmodule

// File: rtl/sound_regs_pkg.sv
// register map of the sound slave
// control register bit positions and divider reset value
// DSP opcodes and command decoder states
package sound_regs_pkg;

    // ----------------------------------------------------------
    // register addresses, 4-bit offsets on the slave
    // ----------------------------------------------------------
    localparam logic [3:0] REG_CTRL      = 4'h0;   // tone/speaker control
    localparam logic [3:0] REG_TONE_LO   = 4'h2;   // tone half period, low byte
    localparam logic [3:0] REG_TONE_HI   = 4'h3;   // tone half period, high byte
    localparam logic [3:0] REG_TONE_AMP  = 4'h4;   // square wave amplitude
    localparam logic [3:0] REG_DIV_LO    = 4'h5;   // clocks per sample, low byte
    localparam logic [3:0] REG_DIV_HI    = 4'h6;   // clocks per sample, high byte
    localparam logic [3:0] REG_SAMPLE_HI = 4'hA;   // upper byte of last mixed sample
    localparam logic [3:0] REG_DSP_DATA  = 4'hC;   // DSP command/data port
    localparam logic [3:0] REG_STATUS    = 4'hE;   // decoder status

    // control register bits
    localparam int CTRL_TONE_EN   = 0;
    localparam int CTRL_SPK_EN    = 1;   // also driven by speaker opcodes
    localparam int CTRL_SPK_LEVEL = 2;   // 1 = high level

    localparam logic [15:0] DIV_RESET = 16'd16;   // clocks per sample out of reset

    // ----------------------------------------------------------
    // DSP command set, subset of the sound-card DSP
    // ----------------------------------------------------------
    typedef enum logic [7:0] {
        DSP_CMD_DAC     = 8'h10,   // next data byte goes to the DAC
        DSP_CMD_SPK_ON  = 8'hD1,
        DSP_CMD_SPK_OFF = 8'hD3
    } dsp_cmd_e;

    typedef enum logic {
        DSP_IDLE     = 1'b0,   // next data write is an opcode
        DSP_WAIT_DAC = 1'b1    // next data write is a DAC byte
    } dsp_state_e;

endpackage

// File: rtl/sound_src_if.sv
`timescale 1ns/1ps
// source samples of one sample tick, voices stage to mixer
// no ready, the mixer takes every valid
interface sound_src_if;
    import sound_audio_pkg::*;

    logic    valid;     // sample tick, single cycle
    sample_t dac;       // converted direct DAC value
    sample_t tone;      // square wave voice
    sample_t speaker;   // PC speaker level

    modport voices (
        output valid,
        output dac,
        output tone,
        output speaker
    );

    modport mixer (
        input valid,
        input dac,
        input tone,
        input speaker
    );

endinterface

// File: rtl/sound_top.sv
`timescale 1ns/1ps
// sound subsystem top level
// Wishbone register slave, voices stage and mixer, plain ports
module sound_top (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        wb_cyc,
    input  logic        wb_stb,
    input  logic        wb_we,
    input  logic [3:0]  wb_adr,
    input  logic [7:0]  wb_dat_w,
    output logic [7:0]  wb_dat_r,
    output logic        wb_ack,
    output logic [15:0] sample,
    output logic        new_sample
);

    logic        ctrl_tone_en;
    logic        ctrl_spk_en;
    logic        ctrl_spk_level;
    logic        dac_enabled;
    logic        dac_load;
    logic [7:0]  dac_value;
    logic [15:0] tone_half_period;
    logic [7:0]  tone_amp;
    logic [15:0] divider;
    logic [7:0]  last_sample_hi;    // mixer back to readback

    sound_src_if src_if ();         // one tick of source samples

    // ----------------------------------------------------------
    // bus slave
    // ----------------------------------------------------------
    sound_wb_regs u_regs (
        .clk              (clk),
        .rst_n            (rst_n),
        .wb_cyc           (wb_cyc),
        .wb_stb           (wb_stb),
        .wb_we            (wb_we),
        .wb_adr           (wb_adr),
        .wb_dat_w         (wb_dat_w),
        .wb_dat_r         (wb_dat_r),
        .wb_ack           (wb_ack),
        .last_sample_hi   (last_sample_hi),
        .ctrl_tone_en     (ctrl_tone_en),
        .ctrl_spk_en      (ctrl_spk_en),
        .ctrl_spk_level   (ctrl_spk_level),
        .dac_enabled      (dac_enabled),
        .dac_load         (dac_load),
        .dac_value        (dac_value),
        .tone_half_period (tone_half_period),
        .tone_amp         (tone_amp),
        .divider          (divider)
    );

    // ----------------------------------------------------------
    // sources and mixer
    // ----------------------------------------------------------
    sound_voices u_voices (
        .clk              (clk),
        .rst_n            (rst_n),
        .ctrl_tone_en     (ctrl_tone_en),
        .ctrl_spk_en      (ctrl_spk_en),
        .ctrl_spk_level   (ctrl_spk_level),
        .dac_enabled      (dac_enabled),
        .dac_load         (dac_load),
        .dac_value        (dac_value),
        .tone_half_period (tone_half_period),
        .tone_amp         (tone_amp),
        .divider          (divider),
        .src              (src_if)
    );

    sound_mixer u_mixer (
        .clk            (clk),
        .rst_n          (rst_n),
        .src            (src_if),
        .sample         (sample),
        .new_sample     (new_sample),
        .last_sample_hi (last_sample_hi)
    );

endmodule

// File: rtl/sound_voices.sv
`timescale 1ns/1ps
// sample tick generator and the three sound sources
// DAC unsigned to signed conversion, square wave tone, speaker level
// drives one set of source samples per tick
module sound_voices (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        ctrl_tone_en,
    input  logic        ctrl_spk_en,
    input  logic        ctrl_spk_level,
    input  logic        dac_enabled,
    input  logic        dac_load,
    input  logic [7:0]  dac_value,
    input  logic [15:0] tone_half_period,
    input  logic [7:0]  tone_amp,
    input  logic [15:0] divider,
    sound_src_if.voices src
);
    import sound_audio_pkg::*;

    logic [15:0] tick_cnt;    // clocks left to next tick
    logic        tick;
    logic [7:0]  dac_hold;    // last byte loaded through the DSP port
    logic [15:0] tone_cnt;    // ticks spent in current half period
    logic        tone_pos;    // square wave phase, 1 = positive
    sample_t     dac_s;
    sample_t     tone_mag;
    sample_t     tone_s;
    sample_t     spk_s;

    // ----------------------------------------------------------
    // sample tick, every divider clocks
    // ----------------------------------------------------------
    assign tick = (tick_cnt == 16'd0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tick_cnt <= 16'd0;
        end else if (tick) begin
            tick_cnt <= divider - 16'd1;    // divider is at least 2
        end else begin
            tick_cnt <= tick_cnt - 16'd1;
        end
    end

    // ----------------------------------------------------------
    // DAC hold and square wave phase
    // ----------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dac_hold <= 8'h80;
        end else if (dac_load) begin
            dac_hold <= dac_value;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tone_cnt <= 16'd0;
            tone_pos <= 1'b1;
        end else if (!ctrl_tone_en) begin
            tone_cnt <= 16'd0;              // restart in positive phase
            tone_pos <= 1'b1;
        end else if (tick) begin
            if (tone_cnt + 16'd1 >= tone_half_period) begin
                tone_cnt <= 16'd0;
                tone_pos <= ~tone_pos;      // flip after N ticks
            end else begin
                tone_cnt <= tone_cnt + 16'd1;
            end
        end
    end

    // source values from the current registers
    assign dac_s    = dac_enabled ? sample_t'({~dac_hold[7], dac_hold[6:0], 8'h00}) : '0;
    assign tone_mag = sample_t'({8'h00, tone_amp} << TONE_SHIFT);
    assign tone_s   = !ctrl_tone_en ? '0 : (tone_pos ? tone_mag : -tone_mag);
    assign spk_s    = !ctrl_spk_en ? '0 : (ctrl_spk_level ? SPK_HIGH : SPK_LOW);

    // ----------------------------------------------------------
    // output to the mixer
    // ----------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            src.valid <= 1'b0;
        end else begin
            src.valid <= tick;
        end
    end

    always_ff @(posedge clk) begin
        if (tick) begin
            src.dac     <= dac_s;
            src.tone    <= tone_s;
            src.speaker <= spk_s;
        end
    end

    // relies on the divider floor set in the bus slave
    a_valid_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        src.valid |=> !src.valid);

endmodule

// File: rtl/sound_wb_regs.sv
`timescale 1ns/1ps
// Wishbone classic register slave of the sound block
// register file with divider clamp, DSP command decoder,
// registered readback
module sound_wb_regs (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        wb_cyc,
    input  logic        wb_stb,
    input  logic        wb_we,
    input  logic [3:0]  wb_adr,
    input  logic [7:0]  wb_dat_w,
    output logic [7:0]  wb_dat_r,
    output logic        wb_ack,
    input  logic [7:0]  last_sample_hi,
    output logic        ctrl_tone_en,
    output logic        ctrl_spk_en,
    output logic        ctrl_spk_level,
    output logic        dac_enabled,
    output logic        dac_load,
    output logic [7:0]  dac_value,
    output logic [15:0] tone_half_period,
    output logic [7:0]  tone_amp,
    output logic [15:0] divider
);
    import sound_regs_pkg::*;
    import sound_audio_pkg::*;

    logic        held;        // request taken, stb not yet dropped
    logic        access;      // first cycle of a fresh request
    logic        wr;
    logic [15:0] div_q;       // divider as written
    logic [7:0]  rd_data;
    dsp_state_e  dsp_state;

    assign access  = wb_cyc && wb_stb && !held;
    assign wr      = access && wb_we;
    assign divider = (div_q < DIV_MIN) ? DIV_MIN : div_q;   // floor at two clocks

    // ----------------------------------------------------------
    // bus handshake, ack one cycle after the request
    // ----------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_ack   <= 1'b0;
            held     <= 1'b0;
            wb_dat_r <= 8'h00;
        end else begin
            wb_ack   <= access;
            held     <= wb_stb && (held || access);             // wait for stb low
            wb_dat_r <= (access && !wb_we) ? rd_data : 8'h00;   // valid with ack
        end
    end

    // ----------------------------------------------------------
    // register file and DSP command decoder
    // ----------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ctrl_tone_en     <= 1'b0;
            ctrl_spk_en      <= 1'b0;
            ctrl_spk_level   <= 1'b0;
            tone_half_period <= 16'd0;
            tone_amp         <= 8'd0;
            div_q            <= DIV_RESET;
            dac_enabled      <= 1'b0;
            dac_value        <= 8'h80;      // mid scale, converts to 0
            dac_load         <= 1'b0;
            dsp_state        <= DSP_IDLE;
        end else begin
            dac_load <= 1'b0;               // single pulse per data byte
            if (wr) begin
                case (wb_adr)
                    REG_CTRL: begin
                        ctrl_tone_en   <= wb_dat_w[CTRL_TONE_EN];
                        ctrl_spk_en    <= wb_dat_w[CTRL_SPK_EN];
                        ctrl_spk_level <= wb_dat_w[CTRL_SPK_LEVEL];
                    end
                    REG_TONE_LO:  tone_half_period[7:0]  <= wb_dat_w;
                    REG_TONE_HI:  tone_half_period[15:8] <= wb_dat_w;
                    REG_TONE_AMP: tone_amp               <= wb_dat_w;
                    REG_DIV_LO:   div_q[7:0]             <= wb_dat_w;
                    REG_DIV_HI:   div_q[15:8]            <= wb_dat_w;
                    REG_DSP_DATA: begin
                        if (dsp_state == DSP_WAIT_DAC) begin
                            dac_value <= wb_dat_w;      // data byte of the DAC opcode
                            dac_load  <= 1'b1;
                            dsp_state <= DSP_IDLE;
                        end else begin
                            case (wb_dat_w)
                                DSP_CMD_DAC: begin
                                    dsp_state   <= DSP_WAIT_DAC;
                                    dac_enabled <= 1'b1;
                                end
                                DSP_CMD_SPK_ON:  ctrl_spk_en <= 1'b1;
                                DSP_CMD_SPK_OFF: ctrl_spk_en <= 1'b0;
                                default:         ;          // unknown opcode, no effect
                            endcase
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

    // ----------------------------------------------------------
    // readback mux
    // ----------------------------------------------------------
    always_comb begin
        case (wb_adr)
            REG_CTRL:      rd_data = {5'd0, ctrl_spk_level, ctrl_spk_en, ctrl_tone_en};
            REG_TONE_LO:   rd_data = tone_half_period[7:0];
            REG_TONE_HI:   rd_data = tone_half_period[15:8];
            REG_TONE_AMP:  rd_data = tone_amp;
            REG_DIV_LO:    rd_data = div_q[7:0];
            REG_DIV_HI:    rd_data = div_q[15:8];
            REG_SAMPLE_HI: rd_data = last_sample_hi;
            REG_DSP_DATA:  rd_data = dac_value;
            REG_STATUS:    rd_data = {6'd0, dac_enabled, dsp_state == DSP_WAIT_DAC};
            default:       rd_data = 8'h00;     // unmapped
        endcase
    end

    // a held request must not be acked a second time
    a_ack_single: assert property (@(posedge clk) disable iff (!rst_n)
        wb_ack |=> !wb_ack);

endmodule

// File: include/sound_tb_tasks.svh
// testbench helpers for the sound subsystem
// Wishbone classic write and read, wait for new_sample pulses
// reference model of one mixed sample
`ifndef SOUND_TB_TASKS_SVH
`define SOUND_TB_TASKS_SVH

// ------------------------------------------------------------
// bus access, called 1 ns after a rising edge
// ------------------------------------------------------------
task automatic bus_write(input logic [3:0] adr, input logic [7:0] data);
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = 1'b1;
    wb_adr   = adr;
    wb_dat_w = data;
    @(posedge clk);
    while (!wb_ack) @(posedge clk);   // ack as sampled at the edge
    #1;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
    @(posedge clk);                   // stb low one cycle before the next request
    #1;
endtask

task automatic bus_read(input logic [3:0] adr, input logic [7:0] expected);
    rd_exp = expected;
    rd_chk = 1'b1;                    // readback check armed until ack
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we  = 1'b0;
    wb_adr = adr;
    @(posedge clk);
    while (!wb_ack) @(posedge clk);
    #1;
    rd_chk = 1'b0;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    @(posedge clk);
    #1;
endtask

// returns 1 ns after the edge of the n-th pulse
task automatic wait_samples(input int n);
    repeat (n) begin
        @(posedge clk);
        while (!new_sample) @(posedge clk);
    end
    #1;
endtask

// ------------------------------------------------------------
// reference model
// ------------------------------------------------------------
function automatic int clip16(input int v);
    return (v > 32767) ? 32767 : ((v < -32768) ? -32768 : v);
endfunction

// dac and tone added first, speaker second, each add clipped
function automatic int ref_sample(input logic dac_on, input logic [7:0] dac,
                                  input logic tone_on, input logic tone_neg,
                                  input logic [7:0] amp, input logic spk_on,
                                  input logic spk_high);
    int dac_v;
    int tone_v;
    int spk_v;
    dac_v  = dac_on ? (int'(dac) - 128) * 256 : 0;     // offset binary to signed
    tone_v = tone_on ? int'(amp) * 128 : 0;
    tone_v = tone_neg ? -tone_v : tone_v;
    spk_v  = spk_on ? (spk_high ? 16384 : -16384) : 0;
    return clip16(clip16(dac_v + tone_v) + spk_v);
endfunction

`endif

// File: testbench/tb_sound.sv
`timescale 1ns/1ps
// testbench of the sound subsystem
// bus, rate, speaker, DAC, saturation and tone tests
// concurrent checks, error counts and a cycle limit
module tb_sound;
    import sound_regs_pkg::*;

    localparam int MAX_CYCLES = 20000;  // tests run about 2500 cycles

    logic               clk = 1'b0;
    logic               rst_n;
    logic               wb_cyc;
    logic               wb_stb;
    logic               wb_we;
    logic [3:0]         wb_adr;
    logic [7:0]         wb_dat_w;
    logic [7:0]         wb_dat_r;
    logic               wb_ack;
    logic signed [15:0] sample;
    logic               new_sample;

    logic       rd_chk;                 // readback compare armed
    logic [7:0] rd_exp;
    logic       smp_chk;                // sample compare armed
    int         exp_a;                  // expected, positive tone phase
    int         exp_b;                  // expected, other allowed phase
    logic       rate_chk;
    int         rate_exp;               // clocks between pulses
    int         gap = 0;
    logic       tone_chk;
    int         tone_n;                 // half period in samples
    int         tone_mag;
    int         runs = 0;               // sign runs in the tone window
    int         run_len = 0;
    logic       prev_neg = 1'b0;
    int         min_hits = 0;
    int         cycles = 0;
    int         err_mismatch = 0;
    int         err_other = 0;
    integer     seed;
    logic       m_dac_on;               // model state, mirrors the writes
    logic [7:0] m_dac;
    logic       m_tone_on;
    logic [7:0] m_amp;
    logic       m_spk_on;
    logic       m_spk_high;

    always #5 clk = ~clk;

    sound_top dut (.*);

`include "sound_tb_tasks.svh"

    function automatic void log_mismatch(input string msg);
        err_mismatch++;
        $display("mismatch at %0t ns: %s", $time, msg);
    endfunction

    // ------------------------------------------------------------
    // checks
    // ------------------------------------------------------------
    a_req_ack: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(wb_cyc && wb_stb) |=> wb_ack)
        else log_mismatch("no ack in the cycle after the request");
    a_ack_req: assert property (@(posedge clk) disable iff (!rst_n)
        wb_ack |-> $past(wb_cyc && wb_stb))
        else log_mismatch("ack without a request");
    a_ack_once: assert property (@(posedge clk) disable iff (!rst_n)
        wb_ack |=> !wb_ack)
        else log_mismatch("ack held for two cycles");
    a_readback: assert property (@(posedge clk) disable iff (!rst_n)
        wb_ack && rd_chk |-> wb_dat_r == rd_exp)
        else log_mismatch($sformatf("read %h, expected %h", $sampled(wb_dat_r), rd_exp));
    a_rate: assert property (@(posedge clk) disable iff (!rst_n)
        new_sample && rate_chk |-> gap == rate_exp)
        else log_mismatch($sformatf("pulse gap %0d, expected %0d", $sampled(gap), rate_exp));
    a_sample: assert property (@(posedge clk) disable iff (!rst_n)
        new_sample && smp_chk |-> sample == exp_a || sample == exp_b)
        else log_mismatch($sformatf("sample %0d, expected %0d", $sampled(sample), exp_a));
    a_tone_level: assert property (@(posedge clk) disable iff (!rst_n)
        new_sample && tone_chk |-> sample == tone_mag || sample == -tone_mag)
        else log_mismatch($sformatf("tone sample %0d", $sampled(sample)));
    a_tone_flip: assert property (@(posedge clk) disable iff (!rst_n)
        new_sample && tone_chk && runs >= 2 && sample[15] != prev_neg |-> run_len == tone_n)
        else log_mismatch($sformatf("tone run of %0d samples", $sampled(run_len)));

    always @(posedge clk) begin
        gap <= new_sample ? 1 : gap + 1;    // clocks since last pulse
        if (new_sample && smp_chk && sample == -32768) begin
            min_hits <= min_hits + 1;
        end
    end

    // sign runs of the tone, the first run may be partial
    always @(posedge clk) begin
        if (!tone_chk) begin
            runs <= 0;
        end else if (new_sample) begin
            if (runs == 0 || sample[15] != prev_neg) begin
                prev_neg <= sample[15];
                run_len  <= 1;
                runs     <= runs + 1;
            end else begin
                run_len <= run_len + 1;
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == MAX_CYCLES) begin
            $display("timeout: tests did not finish within %0d cycles", MAX_CYCLES);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    // ------------------------------------------------------------
    // stimulus helpers
    // ------------------------------------------------------------
    task automatic set_ctrl(input logic tone, input logic spk, input logic high);
        bus_write(REG_CTRL, {5'd0, high, spk, tone});
        m_tone_on  = tone;
        m_spk_on   = spk;
        m_spk_high = high;
    endtask

    task automatic dac_play(input logic [7:0] d);
        bus_write(REG_DSP_DATA, DSP_CMD_DAC);
        bus_read(REG_STATUS, 8'h03);            // waiting for data, DAC on
        bus_write(REG_DSP_DATA, d);
        bus_read(REG_STATUS, 8'h02);
        m_dac_on = 1'b1;
        m_dac    = d;
    endtask

    // flush samples taken before the last write, then compare n
    task automatic check_samples(input logic both, input int n);
        exp_a = ref_sample(m_dac_on, m_dac, m_tone_on, 1'b0, m_amp, m_spk_on, m_spk_high);
        exp_b = ref_sample(m_dac_on, m_dac, m_tone_on, both, m_amp, m_spk_on, m_spk_high);
        wait_samples(3);
        smp_chk = 1'b1;
        wait_samples(n);
        smp_chk = 1'b0;
    endtask

    task automatic check_rate(input int div);
        rate_exp = div;
        wait_samples(3);                        // old period drains first
        rate_chk = 1'b1;
        wait_samples(4);
        rate_chk = 1'b0;
    endtask

    initial begin
        logic [7:0] d;
        seed       = 32'hd191;
        rst_n      = 1'b0;
        wb_cyc     = 1'b0;
        wb_stb     = 1'b0;
        wb_we      = 1'b0;
        wb_adr     = 4'h0;
        wb_dat_w   = 8'h00;
        rd_chk     = 1'b0;
        rd_exp     = 8'h00;
        smp_chk    = 1'b0;
        exp_a      = 0;
        exp_b      = 0;
        rate_chk   = 1'b0;
        rate_exp   = 0;
        tone_chk   = 1'b0;
        tone_n     = 0;
        tone_mag   = 0;
        m_dac_on   = 1'b0;
        m_dac      = 8'h80;
        m_tone_on  = 1'b0;
        m_amp      = 8'h00;
        m_spk_on   = 1'b0;
        m_spk_high = 1'b0;
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(posedge clk);
        #1;

        // bus timing and readback
        bus_read(REG_STATUS, 8'h00);
        bus_read(REG_DIV_LO, 8'h10);
        bus_write(REG_TONE_AMP, 8'hA5);
        m_amp = 8'hA5;
        bus_read(REG_TONE_AMP, 8'hA5);
        bus_write(REG_TONE_LO, 8'h3C);
        bus_read(REG_TONE_LO, 8'h3C);
        bus_read(4'h1, 8'h00);                  // unmapped
        bus_read(4'h7, 8'h00);
        bus_read(4'hF, 8'h00);

        // sample rate, a write of 1 clamps to 2
        check_rate(16);
        bus_write(REG_DIV_LO, 8'd2);
        check_rate(2);
        bus_write(REG_DIV_LO, 8'd1);
        bus_read(REG_DIV_LO, 8'd1);             // raw value reads back
        check_rate(2);
        bus_write(REG_DIV_LO, 8'd16);

        // speaker by control bits and opcodes
        set_ctrl(1'b0, 1'b0, 1'b1);
        check_samples(1'b0, 3);
        bus_write(REG_DSP_DATA, DSP_CMD_SPK_ON);
        m_spk_on = 1'b1;
        bus_read(REG_CTRL, 8'h06);              // opcode sets the control bit
        check_samples(1'b0, 3);
        set_ctrl(1'b0, 1'b1, 1'b0);
        check_samples(1'b0, 3);
        bus_write(REG_DSP_DATA, 8'hAB);         // unknown opcode
        bus_read(REG_CTRL, 8'h02);
        bus_read(REG_STATUS, 8'h00);
        check_samples(1'b0, 3);
        bus_write(REG_DSP_DATA, DSP_CMD_SPK_OFF);
        m_spk_on = 1'b0;
        check_samples(1'b0, 3);

        // direct DAC, random bytes
        repeat (6) begin
            d = 8'($random(seed));
            dac_play(d);
            check_samples(1'b0, 3);
            bus_read(REG_SAMPLE_HI, 8'(exp_a >>> 8));
        end

        // saturation, long half period keeps the positive phase
        dac_play(8'hFF);
        bus_write(REG_TONE_AMP, 8'hFF);
        m_amp = 8'hFF;
        bus_write(REG_TONE_LO, 8'hFF);
        bus_write(REG_TONE_HI, 8'hFF);
        set_ctrl(1'b1, 1'b0, 1'b0);
        check_samples(1'b0, 3);
        set_ctrl(1'b0, 1'b0, 1'b0);             // restart phase later
        dac_play(8'h00);
        bus_write(REG_TONE_LO, 8'h01);          // flips every tick
        bus_write(REG_TONE_HI, 8'h00);
        set_ctrl(1'b1, 1'b1, 1'b0);
        check_samples(1'b1, 6);
        if (min_hits == 0) begin
            err_other++;
            $display("negative saturation never reached full scale");
        end

        // tone alone, DAC at mid scale
        set_ctrl(1'b0, 1'b0, 1'b0);
        dac_play(8'h80);
        bus_write(REG_TONE_AMP, 8'h40);
        bus_write(REG_TONE_LO, 8'd3);
        tone_n   = 3;
        tone_mag = 'h40 * 128;
        set_ctrl(1'b1, 1'b0, 1'b0);
        wait_samples(3);
        tone_chk = 1'b1;
        wait_samples(16);
        tone_chk = 1'b0;
        if (runs < 4) begin
            err_other++;
            $display("tone sign flipped too rarely, %0d runs seen", runs);
        end

        $display("errors: %0d mismatch, %0d other", err_mismatch, err_other);
        if (err_mismatch == 0 && err_other == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule
